// File: Makefile
# Verilator build and run of the idann tile testbench

SIM  := obj_dir/Vtb_idann
SRCS := $(filter-out +%,$(shell cat tb.f)) logic/idann_params.svh

.PHONY: all run clean

all: run

# rebuilt only when a source, the header or the file list changes
$(SIM): tb.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ns -f tb.f \
	  --top-module tb_idann -o Vtb_idann

run: $(SIM)
	$(SIM) 2>&1 | tee sim.log
	@if grep -q '\*\* FAIL \*\*' sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q '\*\* PASS \*\*' sim.log || { echo "no pass line in sim.log"; exit 1; }

clean:
	rm -rf obj_dir sim.log

// File: logic/hidden_neuron.sv
// hidden_neuron module, binary-input weighted sum with relu and output register
`include "idann_params.svh"
`default_nettype none
`timescale 1ns/1ns

module hidden_neuron import idann_pkg::*; (
  input  wire                          clk_i,
  input  wire                          rst_n_i,
  input  wire                          en_i,   // hidden pass strobe
  input  wire  [`IDANN_N_IN-1:0]       x_i,    // binary inputs
  input  weight_t [`IDANN_N_IN-1:0]    w_i,    // one weight per input
  output hid_act_t                     act_o
);

  localparam int SUM_BITS = `IDANN_W_BITS + 2; // four 4-bit terms need 2 guard bits

  logic signed [SUM_BITS-1:0] sum;
  hid_act_t                   relu;
  hid_act_t                   act_q;

  // x is binary so each product is just the weight or nothing
  always_comb begin
    sum = '0;
    for (int k = 0; k < `IDANN_N_IN; k++) begin
      if (x_i[k]) sum = sum + SUM_BITS'(w_i[k]); // sign-extends the weight
    end
  end

  // relu clamps negatives to zero
  assign relu = sum[SUM_BITS-1] ? '0
                                : {{(`IDANN_HID_BITS - SUM_BITS){1'b0}}, sum};

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      act_q <= '0;
    end else if (en_i) begin
      act_q <= relu;
    end
  end

  assign act_o = act_q;

endmodule : hidden_neuron

`default_nettype wire

// File: logic/idann_params.svh
// layer sizes, bit widths and readout byte count for the idann tile
`ifndef IDANN_PARAMS_SVH
`define IDANN_PARAMS_SVH

// network shape
`define IDANN_N_IN       4   // binary inputs
`define IDANN_N_HID      8   // hidden neurons

// datapath widths
`define IDANN_W_BITS     4   // signed weight
`define IDANN_HID_BITS   10  // relu activation, unsigned
`define IDANN_OUT_BITS   23  // output accumulator, signed
`define IDANN_LOSS_BITS  46  // squared error, twice the accumulator

// 32 hidden weights then 8 output weights
`define IDANN_N_WEIGHTS  40

// 3 result bytes + 6 loss bytes on the readout mux
`define IDANN_RD_BYTES   9

`endif

// File: logic/idann_pkg.sv
// idann_pkg with datapath types, pin command structs and sequencer state enum
`default_nettype none
`include "idann_params.svh"

package idann_pkg;

  // datapath scalars
  typedef logic signed [`IDANN_W_BITS-1:0]    weight_t;  // two's complement weight
  typedef logic        [`IDANN_HID_BITS-1:0]  hid_act_t; // relu output, never negative
  typedef logic signed [`IDANN_OUT_BITS-1:0]  out_acc_t; // output neuron sum
  typedef logic        [`IDANN_LOSS_BITS-1:0] loss_t;    // (result - target)^2

  // one weight write from the pins, valid for a single cycle
  typedef struct packed {
    logic       valid;
    logic [5:0] addr;   // bank-local address after decode
    weight_t    w;
  } weight_wr_t;

  // run command, start is a one-cycle strobe
  typedef struct packed {
    logic       start;
    logic [3:0] x;      // binary input vector
    weight_t    target; // signed 4-bit target
  } run_cmd_t;

  // latched outcome of the last run
  typedef struct packed {
    out_acc_t result;
    loss_t    loss;
  } nn_result_t;

  // run sequencer states
  typedef enum logic [2:0] {
    ST_IDLE      = 3'd0,
    ST_HID_PASS  = 3'd1,
    ST_OUT_MAC   = 3'd2,
    ST_LOSS_CALC = 3'd3,
    ST_DONE      = 3'd4
  } nn_state_e;

endpackage : idann_pkg

`default_nettype wire

// File: logic/io_decode.sv
// io_decode module splitting tile pins into weight writes, run commands and readout bytes
`include "idann_params.svh"
`default_nettype none
`timescale 1ns/1ns

module io_decode import idann_pkg::*; (
  input  wire         clk_i,
  input  wire         rst_n_i,
  input  wire  [7:0]  ui_i,
  input  wire  [7:0]  uio_i,
  input  wire         done_i,    // run finished and result stable
  input  nn_result_t  result_i,
  output weight_wr_t  hid_wr_o,  // to hidden bank for addr 0..31
  output weight_wr_t  out_wr_o,  // to output bank rebased to 0..7
  output run_cmd_t    cmd_o,
  output logic [7:0]  uo_o,
  output logic [7:0]  uio_o,
  output logic [7:0]  uio_oe_o
);

  // pin command decode
  logic       wr_cmd;    // ui[6] high
  logic       start_cmd; // ui[7] high and ui[6] low
  logic       rd_cmd;    // neither so ui[3:0] is a byte select
  logic       hid_hit;   // address below 32
  logic       out_hit;   // address 32..39
  logic [3:0] sel_q;     // registered readout select

  // readout image with lsb byte first
  logic [`IDANN_RD_BYTES-1:0][7:0] rd_bytes;

  assign wr_cmd    = ui_i[6];
  assign start_cmd = ui_i[7] & ~ui_i[6];
  assign rd_cmd    = ~ui_i[7] & ~ui_i[6];

  assign hid_hit = ~ui_i[5];                 // 0..31
  assign out_hit = (ui_i[5:3] == 3'b100);    // 32..39 while 40..63 fall through

  // weight write ports are combinational so the bank updates on the next edge
  assign hid_wr_o.valid = wr_cmd & hid_hit;
  assign hid_wr_o.addr  = ui_i[5:0];
  assign hid_wr_o.w     = uio_i[3:0];

  assign out_wr_o.valid = wr_cmd & out_hit;
  assign out_wr_o.addr  = {3'b000, ui_i[2:0]}; // rebase 32..39 to 0..7
  assign out_wr_o.w     = uio_i[3:0];

  // start strobe sampled by the sequencer on this same edge
  assign cmd_o.start  = start_cmd;
  assign cmd_o.x      = ui_i[3:0];
  assign cmd_o.target = uio_i[3:0];

  // select only follows the pins in readout mode
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sel_q <= 4'd0;
    end else if (rd_cmd) begin
      sel_q <= ui_i[3:0];
    end
  end

  // result sign-extended to 24 bits and loss zero-extended to 48 bits
  assign rd_bytes = {2'b00, result_i.loss,
                     result_i.result[`IDANN_OUT_BITS-1], result_i.result};

  assign uo_o = (sel_q < 4'(`IDANN_RD_BYTES)) ? rd_bytes[sel_q] : 8'h00; // 9..15 read zero

  assign uio_o    = {done_i, 7'b000_0000}; // done flag on bidir pin 7
  assign uio_oe_o = 8'h80;                 // only bit 7 drives

endmodule : io_decode

`default_nettype wire

// File: logic/output_neuron.sv
// output_neuron module, serial mac over hidden activations and squared-error loss
`include "idann_params.svh"
`default_nettype none
`timescale 1ns/1ns

module output_neuron import idann_pkg::*; (
  input  wire                           clk_i,
  input  wire                           rst_n_i,
  input  wire                           mac_en_i,   // accumulate this cycle
  input  wire  [2:0]                    mac_idx_i,  // which hidden neuron
  input  wire                           loss_en_i,  // latch result and loss
  input  hid_act_t [`IDANN_N_HID-1:0]   acts_i,
  input  weight_t  [`IDANN_N_HID-1:0]   w_i,
  input  weight_t                       target_i,
  output nn_result_t                    result_o
);

  // unsigned act gets a zero msb so the signed multiply keeps it positive
  localparam int ACT_S_BITS = `IDANN_HID_BITS + 1;
  localparam int PROD_BITS  = ACT_S_BITS + `IDANN_W_BITS;

  hid_act_t                     act_sel;
  weight_t                      w_sel;
  logic signed [ACT_S_BITS-1:0] act_s;
  logic signed [PROD_BITS-1:0]  prod;
  out_acc_t                     prod_ext;
  out_acc_t                     acc_base;   // zero at idx 0 restarts the sum
  out_acc_t                     acc_q;
  out_acc_t                     target_ext;
  out_acc_t                     diff;
  logic signed [`IDANN_LOSS_BITS-1:0] sq;
  nn_result_t                   result_q;

  // pick one neuron per mac cycle, one shared multiplier
  assign act_sel = acts_i[mac_idx_i];
  assign w_sel   = w_i[mac_idx_i];
  assign act_s   = $signed({1'b0, act_sel});
  assign prod    = act_s * w_sel;
  assign prod_ext = {{(`IDANN_OUT_BITS - PROD_BITS){prod[PROD_BITS-1]}}, prod};

  assign acc_base = (mac_idx_i == 3'd0) ? '0 : acc_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      acc_q <= '0;
    end else if (mac_en_i) begin
      acc_q <= acc_base + prod_ext;
    end
  end

  // error against target, sign-extended to accumulator width
  assign target_ext = {{(`IDANN_OUT_BITS - `IDANN_W_BITS){target_i[`IDANN_W_BITS-1]}}, target_i};
  assign diff       = acc_q - target_ext;
  assign sq         = diff * diff;          // 23x23 signed into 46 bits, always >= 0

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      result_q <= '0;
    end else if (loss_en_i) begin
      result_q.result <= acc_q;
      result_q.loss   <= $unsigned(sq);
    end
  end

  assign result_o = result_q;

  // loss must see the finished sum so it cannot share a cycle with the mac
  a_loss_after_mac : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    !(loss_en_i && mac_en_i)
  ) else $error("output_neuron loss_en during mac_en");

endmodule : output_neuron

`default_nettype wire

// File: logic/state_mach.sv
// state_mach module, run sequencer for hidden pass, output mac, loss and done
`include "idann_params.svh"
`default_nettype none
`timescale 1ns/1ns

module state_mach import idann_pkg::*; (
  input  wire         clk_i,
  input  wire         rst_n_i,
  input  run_cmd_t    cmd_i,
  output logic        hid_en_o,   // one cycle, hidden regs load
  output logic        mac_en_o,   // eight cycles of output mac
  output logic [2:0]  mac_idx_o,  // hidden neuron being accumulated
  output logic        loss_en_o,  // result and loss load
  output logic        done_o,
  output logic [3:0]  x_o,        // latched input vector
  output weight_t     target_o    // latched target
);

  nn_state_e  state_q;
  logic [2:0] cnt_q;
  logic [3:0] x_q;
  weight_t    target_q;
  logic       accept;             // start seen while not busy

  // a start mid-run is dropped
  assign accept = cmd_i.start & ((state_q == ST_IDLE) | (state_q == ST_DONE));

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
      cnt_q   <= 3'd0;
    end else begin
      case (state_q)
        ST_IDLE, ST_DONE: if (accept) state_q <= ST_HID_PASS;
        ST_HID_PASS: begin
          state_q <= ST_OUT_MAC;
          cnt_q   <= 3'd0;                    // mac starts at neuron 0
        end
        ST_OUT_MAC: begin
          cnt_q <= cnt_q + 3'd1;
          if (cnt_q == 3'(`IDANN_N_HID - 1)) state_q <= ST_LOSS_CALC;
        end
        ST_LOSS_CALC: state_q <= ST_DONE;
        default:      state_q <= ST_IDLE;
      endcase
    end
  end

  // command payload, only meaningful once a run is accepted
  always_ff @(posedge clk_i) begin
    if (accept) begin
      x_q      <= cmd_i.x;
      target_q <= cmd_i.target;
    end
  end

  assign hid_en_o  = (state_q == ST_HID_PASS);
  assign mac_en_o  = (state_q == ST_OUT_MAC);
  assign mac_idx_o = cnt_q;
  assign loss_en_o = (state_q == ST_LOSS_CALC);
  assign done_o    = (state_q == ST_DONE);
  assign x_o       = x_q;
  assign target_o  = target_q;

  // hidden pass never overlaps mac and hands over to mac index 0
  a_hid_then_mac : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    hid_en_o |-> !mac_en_o ##1 (mac_en_o && mac_idx_o == 3'd0)
  ) else $error("state_mach hid_en overlap or bad mac handover");

  // mac index walks 0..7 one step per cycle
  a_mac_idx_step : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (mac_en_o && mac_idx_o != 3'd0) |-> ($past(mac_en_o) && mac_idx_o == $past(mac_idx_o) + 3'd1)
  ) else $error("state_mach mac_idx %0d out of sequence", mac_idx_o);

endmodule : state_mach

`default_nettype wire

// File: logic/tt_um_idann.sv
// tt_um_idann tile top level wiring decode, weight banks, sequencer and neurons
`include "idann_params.svh"
`default_nettype none
`timescale 1ns/1ns

module tt_um_idann import idann_pkg::*; (
  input  wire        clk_i,
  input  wire        rst_n_i,
  input  wire        ena_i,     // high whenever powered
  input  wire  [7:0] ui_i,      // command pins
  input  wire  [7:0] uio_i,     // weight or target nibble
  output wire  [7:0] uo_o,      // readout byte
  output wire  [7:0] uio_o,     // done flag on bit 7
  output wire  [7:0] uio_oe_o
);

  // pin decode results
  weight_wr_t hid_wr;
  weight_wr_t out_wr;
  run_cmd_t   cmd;
  nn_result_t result;

  // weights, hidden bank is neuron-major
  weight_t [`IDANN_N_HID*`IDANN_N_IN-1:0] hid_w;
  weight_t [`IDANN_N_HID-1:0]             out_w;

  // sequencer outputs
  logic       hid_en;
  logic       mac_en;
  logic [2:0] mac_idx;
  logic       loss_en;
  logic       done;
  logic [3:0] x;
  weight_t    target;

  hid_act_t [`IDANN_N_HID-1:0] acts;

  wire unused_ena = &{1'b0, ena_i}; // tied high on the tile

  io_decode u_io (
    .clk_i    (clk_i),   .rst_n_i  (rst_n_i),
    .ui_i     (ui_i),    .uio_i    (uio_i),
    .done_i   (done),    .result_i (result),
    .hid_wr_o (hid_wr),  .out_wr_o (out_wr),
    .cmd_o    (cmd),
    .uo_o     (uo_o),    .uio_o    (uio_o),    .uio_oe_o (uio_oe_o)
  );

  weight_bank #(.DEPTH(`IDANN_N_HID*`IDANN_N_IN)) u_hid_bank (
    .clk_i (clk_i), .rst_n_i (rst_n_i), .wr_i (hid_wr), .weights_o (hid_w)
  );

  weight_bank #(.DEPTH(`IDANN_N_HID)) u_out_bank (
    .clk_i (clk_i), .rst_n_i (rst_n_i), .wr_i (out_wr), .weights_o (out_w)
  );

  state_mach u_sm (
    .clk_i     (clk_i),   .rst_n_i   (rst_n_i),  .cmd_i    (cmd),
    .hid_en_o  (hid_en),  .mac_en_o  (mac_en),   .mac_idx_o (mac_idx),
    .loss_en_o (loss_en), .done_o    (done),
    .x_o       (x),       .target_o  (target)
  );

  // neuron j takes weights j*4 .. j*4+3
  for (genvar j = 0; j < `IDANN_N_HID; j++) begin : g_hid
    hidden_neuron u_hn (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .en_i    (hid_en),
      .x_i     (x),
      .w_i     (hid_w[j*`IDANN_N_IN +: `IDANN_N_IN]),
      .act_o   (acts[j])
    );
  end

  output_neuron u_on (
    .clk_i     (clk_i),   .rst_n_i   (rst_n_i),
    .mac_en_i  (mac_en),  .mac_idx_i (mac_idx),  .loss_en_i (loss_en),
    .acts_i    (acts),    .w_i       (out_w),    .target_i  (target),
    .result_o  (result)
  );

endmodule : tt_um_idann

`default_nettype wire

// File: logic/weight_bank.sv
// weight_bank module, a register file of signed weights with parallel read
`default_nettype none
`timescale 1ns/1ns

module weight_bank import idann_pkg::*; #(
  parameter int DEPTH = 8
) (
  input  wire                    clk_i,
  input  wire                    rst_n_i,
  input  weight_wr_t             wr_i,      // one write per cycle at most
  output weight_t [DEPTH-1:0]    weights_o  // every entry visible at once
);

  localparam int AW = $clog2(DEPTH); // index bits actually used

  weight_t [DEPTH-1:0] mem_q;

  // weights start at zero so an unloaded net outputs zero
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mem_q <= '0;
    end else if (wr_i.valid) begin
      mem_q[wr_i.addr[AW-1:0]] <= wr_i.w;
    end
  end

  assign weights_o = mem_q;

  // the decoder must have dropped or rebased any address outside this bank
  a_wr_in_range : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    wr_i.valid |-> (wr_i.addr < 6'(DEPTH))
  ) else $error("weight_bank write addr %0d beyond depth %0d", wr_i.addr, DEPTH);

endmodule : weight_bank

`default_nettype wire

// File: tb.f
+incdir+logic
logic/idann_pkg.sv
logic/weight_bank.sv
logic/hidden_neuron.sv
logic/output_neuron.sv
logic/state_mach.sv
logic/io_decode.sv
logic/tt_um_idann.sv
test/tb_idann.sv

// File: test/tb_idann.sv
// tb_idann testbench with clock, reset, xorshift stimulus, reference model, assertions and watchdog
`include "idann_params.svh"
`default_nettype none
`timescale 1ns/1ns

module tb_idann;

  localparam int RESET_CYCLES = 10;
  localparam int N_RAND_RUNS  = 20;
  localparam int N_RUNS       = N_RAND_RUNS + 4;        // rewrite reruns and ignored-start run
  localparam int LOAD_CYCLES  = 3 * `IDANN_N_WEIGHTS;   // two full loads plus stray writes
  localparam int SWEEP_CYCLES = 2 * 16;                 // full readout sweep after reset
  localparam int TIMEOUT_CYCLES = N_RUNS * 40 + RESET_CYCLES + LOAD_CYCLES + SWEEP_CYCLES;
  localparam int DONE_WAIT    = 20;                     // generous bound on run latency

  logic       clk_i;
  logic       rst_n_i;
  logic       ena_i;
  logic [7:0] ui_i;
  logic [7:0] uio_i;
  wire  [7:0] uo_o;
  wire  [7:0] uio_o;
  wire  [7:0] uio_oe_o;

  // reference weights, hidden bank neuron-major like the pin addresses
  longint hid_w [`IDANN_N_HID*`IDANN_N_IN];
  longint out_w [`IDANN_N_HID];

  logic [31:0] rng;
  logic        start_chk;   // high on the cycle a start is expected to be accepted
  logic        byte_chk;    // uo_o must match exp_byte at the next edge
  logic        reset_chk;
  logic [7:0]  exp_byte;
  longint      exp_res;
  longint      exp_loss;

  tt_um_idann dut_i (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .ena_i    (ena_i),
    .ui_i     (ui_i),
    .uio_i    (uio_i),
    .uo_o     (uo_o),
    .uio_o    (uio_o),
    .uio_oe_o (uio_oe_o)
  );

  initial clk_i = 1'b0;
  always #5 clk_i = ~clk_i; // 10 ns period

  task automatic mismatch_stop(input string sig, input logic [63:0] got, input logic [63:0] exp);
    $display("FAILED t=%0t %s got %0h expected %0h", $time, sig, got, exp);
    $display("** FAIL **");
    $fatal(1, "value mismatch on %s", sig);
  endtask

  task automatic abort_run(input string what);
    $display("t=%0t %s", $time, what);
    $display("** FAIL **");
    $fatal(1, "%s", what);
  endtask

  // checkers, all sampled on the rising edge
  a_oe_fixed : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    uio_oe_o == 8'h80)
    else mismatch_stop("uio_oe_o", 64'(uio_oe_o), 64'h80);

  a_uio_low : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    uio_o[6:0] == 7'd0)  // only the done flag may be set
    else mismatch_stop("uio_o[6:0]", 64'(uio_o[6:0]), 64'h0);

  a_reset_idle : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    reset_chk |-> !uio_o[7])
    else mismatch_stop("uio_o[7]", 64'(uio_o[7]), 64'h0);

  a_byte : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    byte_chk |-> uo_o == exp_byte)
    else mismatch_stop("uo_o", 64'(uo_o), 64'(exp_byte));

  // done rises only 10 cycles after the edge that took the start
  a_done_rise : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(uio_o[7]) |-> $past(start_chk, 11))
    else abort_run("done flag rose at a cycle other than 10 after start");

  a_done_due : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $past(start_chk, 11) |-> uio_o[7])
    else abort_run("done flag missing 10 cycles after start");

  a_done_hold : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (uio_o[7] && !(ui_i[7] && !ui_i[6])) |=> uio_o[7])
    else abort_run("done flag dropped without a start command");

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] v;
    v = s;
    v = v ^ (v << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  function automatic logic [3:0] rand_nibble();
    rng = xorshift(rng);
    return rng[3:0];
  endfunction

  // sum over j of relu(sum over k of x_k * w_jk) * v_j
  function automatic longint model_result(input logic [3:0] x);
    longint acc;
    longint h;
    acc = 0;
    for (int j = 0; j < `IDANN_N_HID; j++) begin
      h = 0;
      for (int k = 0; k < `IDANN_N_IN; k++) begin
        if (x[k]) h = h + hid_w[j*`IDANN_N_IN + k]; // binary input gates the weight
      end
      if (h < 0) h = 0;                              // relu
      acc = acc + h * out_w[j];
    end
    return acc;
  endfunction

  function automatic longint model_loss(input longint res, input logic [3:0] t);
    longint d;
    d = res - longint'($signed(t));
    return d * d;
  endfunction

  // readout map, result bytes 0..2 then loss bytes 3..8, rest zero
  function automatic logic [7:0] expected_byte(input int sel);
    if (sel < 3) return exp_res[8*sel +: 8];       // longint already sign-extended
    else if (sel < 9) return exp_loss[8*(sel-3) +: 8];
    else return 8'h00;
  endfunction

  task automatic tick();
    @(posedge clk_i);
    #1; // drive away from the edge
  endtask

  task automatic write_weight(input logic [5:0] addr, input logic [3:0] w);
    ui_i  = {2'b01, addr};
    uio_i = {4'h0, w};
    tick();
    if (addr < 6'd32) hid_w[addr[4:0]] = longint'($signed(w));
    else if (addr < 6'd40) out_w[addr[2:0]] = longint'($signed(w));
    // 40..63 land nowhere
    ui_i  = 8'h00;
    uio_i = 8'h00;
  endtask

  task automatic load_random_weights();
    for (int a = 0; a < `IDANN_N_WEIGHTS; a++) begin
      write_weight(6'(a), rand_nibble());
    end
  endtask

  task automatic check_byte(input logic [3:0] sel, input logic [7:0] exp);
    ui_i = {4'h0, sel};
    tick();              // select registered here
    exp_byte = exp;
    byte_chk = 1'b1;
    tick();              // a_byte samples uo_o on this edge
    byte_chk = 1'b0;
  endtask

  task automatic check_readout(input bit upper);
    for (int s = 0; s < `IDANN_RD_BYTES; s++) check_byte(4'(s), expected_byte(s));
    if (upper) begin
      for (int s = `IDANN_RD_BYTES; s < 16; s++) check_byte(4'(s), 8'h00);
    end
  endtask

  // start a run, optionally poke a second start mid-run, then read back
  task automatic run_and_check(input logic [3:0] x, input logic [3:0] t,
                               input bit intrude, input bit upper);
    int waited;
    exp_res   = model_result(x);
    exp_loss  = model_loss(exp_res, t);
    ui_i      = {4'b1000, x};
    uio_i     = {4'h0, t};
    start_chk = 1'b1;
    tick();
    start_chk = 1'b0;
    waited    = 0;
    while (uio_o[7] !== 1'b1 && waited < DONE_WAIT) begin
      ui_i  = (intrude && waited == 3) ? {4'b1000, ~x} : 8'h00; // must be ignored
      uio_i = (intrude && waited == 3) ? {4'h0, ~t} : 8'h00;
      tick();
      waited++;
    end
    ui_i  = 8'h00;
    uio_i = 8'h00;
    if (uio_o[7] !== 1'b1) abort_run("done flag never rose after start");
    else check_readout(upper);
  endtask

  initial begin
    logic [3:0] x;
    logic [3:0] t;
    logic [5:0] a;
    rng       = 32'he845_b50e;
    rst_n_i   = 1'b0;
    ena_i     = 1'b1;
    ui_i      = 8'h00;
    uio_i     = 8'h00;
    start_chk = 1'b0;
    byte_chk  = 1'b0;
    reset_chk = 1'b0;
    exp_byte  = 8'h00;
    exp_res   = 0;
    exp_loss  = 0;
    for (int i = 0; i < `IDANN_N_HID*`IDANN_N_IN; i++) hid_w[i] = 0;
    for (int i = 0; i < `IDANN_N_HID; i++) out_w[i] = 0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;

    // idle tile reads all zero
    reset_chk = 1'b1;
    tick();
    reset_chk = 1'b0;
    check_readout(1'b1);

    load_random_weights();
    for (int i = 0; i < N_RAND_RUNS; i++) begin
      if (i == N_RAND_RUNS / 2) load_random_weights(); // fresh net halfway
      x = rand_nibble();
      t = rand_nibble();
      if (i == 0) x = 4'h0;
      if (i == 1) x = 4'hf;
      if (i == 2) t = 4'h8;                          // most negative target
      run_and_check(x, t, 1'b0, (i % 5 == 0));
    end

    // single weight rewrites, all inputs on so every hidden weight counts
    x = 4'hf;
    t = rand_nibble();
    rng = xorshift(rng);
    a = 6'(rng % 32'd32);
    write_weight(a, rand_nibble());
    run_and_check(x, t, 1'b0, 1'b0);
    rng = xorshift(rng);
    a = {3'b100, rng[2:0]};                           // output bank 32..39
    write_weight(a, rand_nibble());
    run_and_check(x, t, 1'b0, 1'b0);
    for (int j = 40; j < 64; j++) write_weight(6'(j), rand_nibble());
    run_and_check(x, t, 1'b0, 1'b1);                  // stray writes change nothing

    // second start during the run is dropped
    run_and_check(rand_nibble(), rand_nibble(), 1'b1, 1'b0);

    $display("** PASS **");
    $finish;
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk_i);
    abort_run("watchdog expired before the tests finished");
  end

endmodule : tb_idann

`default_nettype wire
